/* logic/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// architectural data width
`define RV_XLEN 32

// integer register count, x0 included
`define RV_NREGS 32

// data memory depth in words, kept a power of two
`define RV_DMEM_WORDS 64

`endif

/* logic/rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

    typedef logic [4:0] rv32i_reg;
    typedef logic [`RV_XLEN-1:0] rv32i_word;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    // operand source at the ALU inputs
    // for store data, id_ex means the value captured in EX is kept
    typedef enum logic [1:0] {
        id_ex,
        ex_mem,
        mem_wb
    } fwd_sel_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

endpackage

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      we_i,
    input  rv32i_reg  waddr_i,
    input  rv32i_word wdata_i,
    input  rv32i_reg  raddr1_i,
    input  rv32i_reg  raddr2_i,
    output rv32i_word rdata1_o,
    output rv32i_word rdata2_o
);

    rv32i_word regs [`RV_NREGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-first, so an instruction three behind the writer sees the new value
    // x0 is neither written nor bypassed
    assign rdata1_o = (we_i && (waddr_i != '0) && (waddr_i == raddr1_i)) ? wdata_i :
                      regs[raddr1_i];
    assign rdata2_o = (we_i && (waddr_i != '0) && (waddr_i == raddr2_i)) ? wdata_i :
                      regs[raddr2_i];

    // x0 stays zero even while a write to it is presented
    a_x0_reads_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ((raddr1_i == '0) |-> (rdata1_o == '0)) and ((raddr2_i == '0) |-> (rdata2_o == '0)))
        else $error("x0 read returned a nonzero value");

endmodule

/* logic/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode
    import rv_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      instr_valid_i,
    input  rv32i_word instr_i,
    input  logic      wb_we_i,
    input  rv32i_reg  wb_rd_i,
    input  rv32i_word wb_data_i,
    output logic      stall_o,
    output logic      id_ex_valid_o,
    output rv32i_reg  id_ex_rs1_o,
    output rv32i_reg  id_ex_rs2_o,
    output rv32i_reg  id_ex_rd_o,
    output logic      id_ex_reg_write_o,
    output logic      id_ex_mem_read_o,
    output logic      id_ex_mem_write_o,
    output logic      id_ex_use_imm_o,
    output rv32i_word id_ex_imm_o,
    output alu_op_t   id_ex_alu_op_o,
    output rv32i_word id_ex_rs1_data_o,
    output rv32i_word id_ex_rs2_data_o
);

    logic       dec_valid;
    logic       dec_reg_write;
    logic       dec_mem_read;
    logic       dec_mem_write;
    logic       dec_use_imm;
    logic       uses_rs2;
    rv32i_reg   dec_rs1;
    rv32i_reg   dec_rs2;
    rv32i_reg   dec_rd;
    rv32i_word  dec_imm;
    alu_op_t    dec_alu_op;
    rv32i_word  rs1_data;
    rv32i_word  rs2_data;
    logic       load_pending;
    logic       take;

    always_comb begin
        dec_valid     = 1'b0;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_use_imm   = 1'b1;
        uses_rs2      = 1'b0;
        dec_alu_op    = alu_add;
        dec_imm       = {{20{instr_i[31]}}, instr_i[31:20]};
        case (instr_i[6:0])
            op_reg: begin
                dec_valid     = 1'b1;
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b0;
                uses_rs2      = 1'b1;
                case ({instr_i[31:25], instr_i[14:12]})
                    {7'b0000000, 3'b000}: dec_alu_op = alu_add;
                    {7'b0100000, 3'b000}: dec_alu_op = alu_sub;
                    {7'b0000000, 3'b111}: dec_alu_op = alu_and;
                    {7'b0000000, 3'b110}: dec_alu_op = alu_or;
                    {7'b0000000, 3'b100}: dec_alu_op = alu_xor;
                    {7'b0000000, 3'b010}: dec_alu_op = alu_slt;
                    default: begin
                        dec_valid     = 1'b0;
                        dec_reg_write = 1'b0;
                    end
                endcase
            end
            op_imm: begin
                dec_valid     = (instr_i[14:12] == 3'b000);
                dec_reg_write = dec_valid;
            end
            op_load: begin
                dec_valid     = (instr_i[14:12] == 3'b010);
                dec_reg_write = dec_valid;
                dec_mem_read  = dec_valid;
            end
            op_store: begin
                dec_valid     = (instr_i[14:12] == 3'b010);
                dec_mem_write = dec_valid;
                uses_rs2      = 1'b1;
                // S-type splits the offset around rd
                dec_imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            default: ;
        endcase
    end

    assign dec_rs1 = instr_i[19:15];
    assign dec_rs2 = uses_rs2 ? instr_i[24:20] : '0;
    assign dec_rd  = dec_reg_write ? instr_i[11:7] : '0;

    rv_regfile i_rv_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (dec_rs1),
        .raddr2_i (dec_rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    // load result not ready in EX yet; a store's rs2 is covered in MEM
    assign load_pending = id_ex_valid_o && id_ex_mem_read_o && (id_ex_rd_o != '0);
    assign stall_o = instr_valid_i && dec_valid && load_pending &&
                     ((dec_rs1 == id_ex_rd_o) || (!dec_use_imm && (dec_rs2 == id_ex_rd_o)));
    assign take = instr_valid_i && !stall_o;

    // a stalled or missing instruction enters as a bubble
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_valid_o     <= 1'b0;
            id_ex_reg_write_o <= 1'b0;
            id_ex_mem_read_o  <= 1'b0;
            id_ex_mem_write_o <= 1'b0;
        end else begin
            id_ex_valid_o     <= take && dec_valid;
            id_ex_reg_write_o <= take && dec_reg_write;
            id_ex_mem_read_o  <= take && dec_mem_read;
            id_ex_mem_write_o <= take && dec_mem_write;
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex_rs1_o      <= dec_rs1;
        id_ex_rs2_o      <= dec_rs2;
        id_ex_rd_o       <= dec_rd;
        id_ex_use_imm_o  <= dec_use_imm;
        id_ex_imm_o      <= dec_imm;
        id_ex_alu_op_o   <= dec_alu_op;
        id_ex_rs1_data_o <= rs1_data;
        id_ex_rs2_data_o <= rs2_data;
    end

    // one bubble per stall, and the held instruction goes next cycle
    a_stall_inserts_bubble: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |=> (!id_ex_valid_o && !stall_o))
        else $error("stall did not leave a single bubble in ID/EX");

endmodule

/* logic/rv_forwarder.sv */
`timescale 1ns/1ps

module rv_forwarder
    import rv_pkg::*;
(
    input  rv32i_reg id_ex_rs1_i,
    input  rv32i_reg id_ex_rs2_i,
    input  rv32i_reg ex_mem_rd_i,
    input  rv32i_reg mem_wb_rd_i,
    input  rv32i_reg ex_mem_rs2_i,
    input  logic     mem_load_regfile_i,
    input  logic     wb_load_regfile_i,
    output fwd_sel_t forward_a_o,
    output fwd_sel_t forward_b_o,
    output fwd_sel_t forward_c_o
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic wb_hit_c;

    // a stage writing x0 never forwards
    function automatic logic writes_src(logic we, rv32i_reg rd, rv32i_reg src);
        return we && (rd != '0) && (rd == src);
    endfunction

    // nearer stage holds the younger value
    function automatic fwd_sel_t pick_source(logic ex_hit, logic wb_hit);
        if (ex_hit) begin
            return ex_mem;
        end
        if (wb_hit) begin
            return mem_wb;
        end
        return id_ex;
    endfunction

    assign ex_hit_a = writes_src(mem_load_regfile_i, ex_mem_rd_i, id_ex_rs1_i);
    assign ex_hit_b = writes_src(mem_load_regfile_i, ex_mem_rd_i, id_ex_rs2_i);
    assign wb_hit_a = writes_src(wb_load_regfile_i, mem_wb_rd_i, id_ex_rs1_i);
    assign wb_hit_b = writes_src(wb_load_regfile_i, mem_wb_rd_i, id_ex_rs2_i);

    // store data in MEM fed by the instruction now in WB
    assign wb_hit_c = writes_src(wb_load_regfile_i, mem_wb_rd_i, ex_mem_rs2_i);

    assign forward_a_o = pick_source(ex_hit_a, wb_hit_a);
    assign forward_b_o = pick_source(ex_hit_b, wb_hit_b);
    assign forward_c_o = wb_hit_c ? mem_wb : id_ex;

endmodule

/* logic/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute
    import rv_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      id_ex_valid_i,
    input  rv32i_reg  id_ex_rs1_i,
    input  rv32i_reg  id_ex_rs2_i,
    input  rv32i_reg  id_ex_rd_i,
    input  logic      id_ex_reg_write_i,
    input  logic      id_ex_mem_read_i,
    input  logic      id_ex_mem_write_i,
    input  logic      id_ex_use_imm_i,
    input  rv32i_word id_ex_imm_i,
    input  alu_op_t   id_ex_alu_op_i,
    input  rv32i_word id_ex_rs1_data_i,
    input  rv32i_word id_ex_rs2_data_i,
    input  logic      wb_we_i,
    input  rv32i_reg  wb_rd_i,
    input  rv32i_word wb_data_i,
    output logic      ex_mem_valid_o,
    output rv32i_reg  ex_mem_rd_o,
    output rv32i_reg  ex_mem_rs2_o,
    output logic      ex_mem_reg_write_o,
    output logic      ex_mem_mem_read_o,
    output logic      ex_mem_mem_write_o,
    output rv32i_word ex_mem_alu_result_o,
    output rv32i_word ex_mem_store_data_o,
    output fwd_sel_t  fwd_c_o
);

    fwd_sel_t  forward_a;
    fwd_sel_t  forward_b;
    rv32i_word operand_a;
    rv32i_word rs2_value;
    rv32i_word operand_b;
    rv32i_word alu_result;

    function automatic rv32i_word fwd_value(fwd_sel_t sel, rv32i_word id_value,
                                            rv32i_word ex_value, rv32i_word wb_value);
        case (sel)
            ex_mem:  return ex_value;
            mem_wb:  return wb_value;
            default: return id_value;
        endcase
    endfunction

    rv_forwarder i_rv_forwarder (
        .id_ex_rs1_i        (id_ex_rs1_i),
        .id_ex_rs2_i        (id_ex_rs2_i),
        .ex_mem_rd_i        (ex_mem_rd_o),
        .mem_wb_rd_i        (wb_rd_i),
        .ex_mem_rs2_i       (ex_mem_rs2_o),
        .mem_load_regfile_i (ex_mem_reg_write_o),
        .wb_load_regfile_i  (wb_we_i),
        .forward_a_o        (forward_a),
        .forward_b_o        (forward_b),
        .forward_c_o        (fwd_c_o)
    );

    assign operand_a = fwd_value(forward_a, id_ex_rs1_data_i, ex_mem_alu_result_o, wb_data_i);
    assign rs2_value = fwd_value(forward_b, id_ex_rs2_data_i, ex_mem_alu_result_o, wb_data_i);
    assign operand_b = id_ex_use_imm_i ? id_ex_imm_i : rs2_value;

    always_comb begin
        case (id_ex_alu_op_i)
            alu_sub: alu_result = operand_a - operand_b;
            alu_and: alu_result = operand_a & operand_b;
            alu_or:  alu_result = operand_a | operand_b;
            alu_xor: alu_result = operand_a ^ operand_b;
            alu_slt: alu_result = rv32i_word'($signed(operand_a) < $signed(operand_b));
            default: alu_result = operand_a + operand_b;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_valid_o     <= 1'b0;
            ex_mem_reg_write_o <= 1'b0;
            ex_mem_mem_read_o  <= 1'b0;
            ex_mem_mem_write_o <= 1'b0;
        end else begin
            ex_mem_valid_o     <= id_ex_valid_i;
            ex_mem_reg_write_o <= id_ex_reg_write_i;
            ex_mem_mem_read_o  <= id_ex_mem_read_i;
            ex_mem_mem_write_o <= id_ex_mem_write_i;
        end
    end

    // store data leaves EX already forwarded
    always_ff @(posedge clk_i) begin
        ex_mem_rd_o         <= id_ex_rd_i;
        ex_mem_rs2_o        <= id_ex_rs2_i;
        ex_mem_alu_result_o <= alu_result;
        ex_mem_store_data_o <= rs2_value;
    end

    a_bubble_stays_bubble: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !id_ex_valid_i |=> !(ex_mem_valid_o || ex_mem_reg_write_o ||
                             ex_mem_mem_read_o || ex_mem_mem_write_o))
        else $error("bubble left EX with side effects");

endmodule

/* logic/rv_result.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_result
    import rv_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      ex_mem_valid_i,
    input  rv32i_reg  ex_mem_rd_i,
    input  logic      ex_mem_reg_write_i,
    input  logic      ex_mem_mem_read_i,
    input  logic      ex_mem_mem_write_i,
    input  rv32i_word ex_mem_alu_result_i,
    input  rv32i_word ex_mem_store_data_i,
    input  fwd_sel_t  fwd_c_i,
    output logic      wb_we_o,
    output rv32i_reg  wb_rd_o,
    output rv32i_word wb_data_o,
    output logic      wb_valid_o
);

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    rv32i_word       dmem [`RV_DMEM_WORDS];
    logic [AW-1:0]   addr;
    rv32i_word       store_value;
    rv32i_word       load_data;

    // word index, upper address bits wrap
    assign addr = ex_mem_alu_result_i[AW+1:2];

    // load in WB feeding a store right behind it
    assign store_value = (fwd_c_i == mem_wb) ? wb_data_o : ex_mem_store_data_i;
    assign load_data   = dmem[addr];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_valid_i && ex_mem_mem_write_i) begin
            dmem[addr] <= store_value;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= ex_mem_valid_i && ex_mem_reg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o   <= ex_mem_rd_i;
        wb_data_o <= ex_mem_mem_read_i ? load_data : ex_mem_alu_result_i;
    end

    // x0 writes are dropped here and in the register file
    assign wb_valid_o = wb_we_o && (wb_rd_o != '0);

    a_word_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ex_mem_valid_i && (ex_mem_mem_read_i || ex_mem_mem_write_i))
            |-> (ex_mem_alu_result_i[1:0] == 2'b00))
        else $error("misaligned data memory access");

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top
    import rv_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      instr_valid_i,
    input  rv32i_word instr_i,
    output logic      stall_o,
    output logic      wb_valid_o,
    output rv32i_reg  wb_rd_o,
    output rv32i_word wb_data_o
);

    logic      id_ex_valid;
    rv32i_reg  id_ex_rs1;
    rv32i_reg  id_ex_rs2;
    rv32i_reg  id_ex_rd;
    logic      id_ex_reg_write;
    logic      id_ex_mem_read;
    logic      id_ex_mem_write;
    logic      id_ex_use_imm;
    rv32i_word id_ex_imm;
    alu_op_t   id_ex_alu_op;
    rv32i_word id_ex_rs1_data;
    rv32i_word id_ex_rs2_data;
    logic      ex_mem_valid;
    rv32i_reg  ex_mem_rd;
    logic      ex_mem_reg_write;
    logic      ex_mem_mem_read;
    logic      ex_mem_mem_write;
    rv32i_word ex_mem_alu_result;
    rv32i_word ex_mem_store_data;
    fwd_sel_t  fwd_c;
    logic      wb_we;

    rv_decode i_rv_decode (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .wb_we_i           (wb_we),
        .wb_rd_i           (wb_rd_o),
        .wb_data_i         (wb_data_o),
        .stall_o           (stall_o),
        .id_ex_valid_o     (id_ex_valid),
        .id_ex_rs1_o       (id_ex_rs1),
        .id_ex_rs2_o       (id_ex_rs2),
        .id_ex_rd_o        (id_ex_rd),
        .id_ex_reg_write_o (id_ex_reg_write),
        .id_ex_mem_read_o  (id_ex_mem_read),
        .id_ex_mem_write_o (id_ex_mem_write),
        .id_ex_use_imm_o   (id_ex_use_imm),
        .id_ex_imm_o       (id_ex_imm),
        .id_ex_alu_op_o    (id_ex_alu_op),
        .id_ex_rs1_data_o  (id_ex_rs1_data),
        .id_ex_rs2_data_o  (id_ex_rs2_data)
    );

    // EX/MEM rs2 stays inside execute for select C
    rv_execute i_rv_execute (
        .clk_i               (clk_i),
        .arst_n_i            (arst_n_i),
        .id_ex_valid_i       (id_ex_valid),
        .id_ex_rs1_i         (id_ex_rs1),
        .id_ex_rs2_i         (id_ex_rs2),
        .id_ex_rd_i          (id_ex_rd),
        .id_ex_reg_write_i   (id_ex_reg_write),
        .id_ex_mem_read_i    (id_ex_mem_read),
        .id_ex_mem_write_i   (id_ex_mem_write),
        .id_ex_use_imm_i     (id_ex_use_imm),
        .id_ex_imm_i         (id_ex_imm),
        .id_ex_alu_op_i      (id_ex_alu_op),
        .id_ex_rs1_data_i    (id_ex_rs1_data),
        .id_ex_rs2_data_i    (id_ex_rs2_data),
        .wb_we_i             (wb_we),
        .wb_rd_i             (wb_rd_o),
        .wb_data_i           (wb_data_o),
        .ex_mem_valid_o      (ex_mem_valid),
        .ex_mem_rd_o         (ex_mem_rd),
        .ex_mem_rs2_o        (),
        .ex_mem_reg_write_o  (ex_mem_reg_write),
        .ex_mem_mem_read_o   (ex_mem_mem_read),
        .ex_mem_mem_write_o  (ex_mem_mem_write),
        .ex_mem_alu_result_o (ex_mem_alu_result),
        .ex_mem_store_data_o (ex_mem_store_data),
        .fwd_c_o             (fwd_c)
    );

    rv_result i_rv_result (
        .clk_i               (clk_i),
        .arst_n_i            (arst_n_i),
        .ex_mem_valid_i      (ex_mem_valid),
        .ex_mem_rd_i         (ex_mem_rd),
        .ex_mem_reg_write_i  (ex_mem_reg_write),
        .ex_mem_mem_read_i   (ex_mem_mem_read),
        .ex_mem_mem_write_i  (ex_mem_mem_write),
        .ex_mem_alu_result_i (ex_mem_alu_result),
        .ex_mem_store_data_i (ex_mem_store_data),
        .fwd_c_i             (fwd_c),
        .wb_we_o             (wb_we),
        .wb_rd_o             (wb_rd_o),
        .wb_data_o           (wb_data_o),
        .wb_valid_o          (wb_valid_o)
    );

endmodule

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core
    import rv_pkg::*;
();

    localparam int RANDOM_INSTRS   = 200;
    // 11 + 10 + 8 + 9 + 5 instructions in the directed tests
    localparam int DIRECTED_INSTRS = 43;
    localparam int TIMEOUT_CYCLES  = (DIRECTED_INSTRS + RANDOM_INSTRS) * 2 + 20;

    logic      clk_i = 1'b0;
    logic      arst_n_i;
    logic      instr_valid_i;
    rv32i_word instr_i;
    logic      stall_o;
    logic      wb_valid_o;
    rv32i_reg  wb_rd_o;
    rv32i_word wb_data_o;

    // reference model state
    rv32i_word   model_regs [`RV_NREGS];
    rv32i_word   model_mem [`RV_DMEM_WORDS];
    // expected writebacks as a ring, popped on each wb_valid_o pulse
    rv32i_reg    exp_rd [512];
    rv32i_word   exp_data [512];
    logic [8:0]  exp_head;
    logic [8:0]  exp_tail;
    rv32i_reg    idex_load_rd;
    logic        stall_expected;
    logic [31:0] lcg_state;
    int          fail_count   = 0;
    int          stall_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    rv_core_top i_rv_core_top (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic rv32i_word alu_word(alu_op_t op, rv32i_reg rd,
                                           rv32i_reg rs1, rv32i_reg rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (op == alu_sub) ? 7'b0100000 : 7'b0000000;
        case (op)
            alu_and: f3 = 3'b111;
            alu_or:  f3 = 3'b110;
            alu_xor: f3 = 3'b100;
            alu_slt: f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic rv32i_word addi_word(rv32i_reg rd, rv32i_reg rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_imm};
    endfunction

    // loads and stores always use x0 as the base
    function automatic rv32i_word load_word(rv32i_reg rd, logic [11:0] offset);
        return {offset, 5'd0, 3'b010, rd, op_load};
    endfunction

    function automatic rv32i_word store_word(rv32i_reg rs2, logic [11:0] offset);
        return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], op_store};
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int mem_index(rv32i_word addr);
        return int'((addr >> 2) % `RV_DMEM_WORDS);
    endfunction

    // x0..x7 and eight word addresses, upper LCG bits only
    function automatic rv32i_word random_instr(logic [31:0] r1, logic [31:0] r2);
        rv32i_reg    rd;
        rv32i_reg    rs1;
        rv32i_reg    rs2;
        logic [11:0] mem_off;
        rd      = {2'b00, r1[18:16]};
        rs1     = {2'b00, r1[21:19]};
        rs2     = {2'b00, r1[24:22]};
        mem_off = {7'b0, r1[27:25], 2'b00};
        case (r1[31:28])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: return alu_word(alu_op_t'(r1[30:28]), rd, rs1, rs2);
            4'd6, 4'd7, 4'd8: return addi_word(rd, rs1, r2[31:20]);
            4'd9, 4'd10, 4'd11: return load_word(rd, mem_off);
            default: return store_word(rs2, mem_off);
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        fail_count++;
    endtask

    // architectural effect of one accepted instruction
    task automatic model_execute(input rv32i_word w);
        rv32i_reg  rd;
        rv32i_word a;
        rv32i_word b;
        rv32i_word res;
        logic      writes;
        rd     = w[11:7];
        a      = model_regs[w[19:15]];
        b      = model_regs[w[24:20]];
        res    = '0;
        writes = 1'b1;
        case (w[6:0])
            op_reg: begin
                case (w[14:12])
                    3'b000:  res = w[30] ? a - b : a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    3'b100:  res = a ^ b;
                    default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            op_imm:  res = a + {{20{w[31]}}, w[31:20]};
            op_load: res = model_mem[mem_index(a + {{20{w[31]}}, w[31:20]})];
            op_store: begin
                model_mem[mem_index(a + {{20{w[31]}}, w[31:25], w[11:7]})] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && (rd != '0)) begin
            model_regs[rd] = res;
            exp_rd[exp_tail]   <= rd;
            exp_data[exp_tail] <= res;
            exp_tail           <= exp_tail + 9'd1;
        end
    endtask

    // a load accepted at this edge sits in ID/EX for the next cycle
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idex_load_rd <= '0;
        end else if (instr_valid_i && !stall_o && (instr_i[6:0] == op_load)) begin
            idex_load_rd <= instr_i[11:7];
        end else begin
            idex_load_rd <= '0;
        end
    end

    // EX reads rs1 always, rs2 only for register-register ops
    assign stall_expected = instr_valid_i && (idex_load_rd != '0) &&
                            ((instr_i[19:15] == idex_load_rd) ||
                             ((instr_i[6:0] == op_reg) && (instr_i[24:20] == idex_load_rd)));

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_head <= '0;
        end else if (wb_valid_o && (exp_head != exp_tail)) begin
            exp_head <= exp_head + 9'd1;
        end
    end

    a_wb_expected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_o |-> ((exp_head != exp_tail) && (wb_rd_o == exp_rd[exp_head]) &&
                        (wb_data_o == exp_data[exp_head])))
        else report_error($sformatf("writeback x%0d = %h does not match the model",
                                    $sampled(wb_rd_o), $sampled(wb_data_o)));

    a_stall_rule: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o == stall_expected)
        else report_error($sformatf("stall_o = %0b, load-use rule gives %0b",
                                    $sampled(stall_o), $sampled(stall_expected)));

    a_stall_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |=> !stall_o)
        else report_error("stall_o stayed high for a second cycle");

    // holds the instruction until the edge that takes it
    task automatic issue_instr(input rv32i_word w);
        instr_valid_i <= 1'b1;
        instr_i       <= w;
        @(posedge clk_i);
        while (stall_o) begin
            stall_count++;
            @(posedge clk_i);
        end
        model_execute(w);
    endtask

    task automatic drain_pipeline();
        instr_valid_i <= 1'b0;
        // last writeback is sampled three edges after acceptance
        repeat (4) @(posedge clk_i);
        a_drained: assert (exp_head == exp_tail)
            else report_error("expected writebacks never arrived");
    endtask

    task automatic finish_test(input string name, input int errors_before,
                               input int stalls_before);
        if (fail_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok, %0d stall cycles", name, stall_count - stalls_before);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, fail_count - errors_before);
        end
    endtask

    task automatic independent_alu();
        int errors_before;
        int stalls_before;
        errors_before = fail_count;
        stalls_before = stall_count;
        issue_instr(addi_word(5'd1, 5'd0, 12'd5));
        // -3
        issue_instr(addi_word(5'd2, 5'd0, 12'hffd));
        issue_instr(addi_word(5'd3, 5'd0, 12'd100));
        issue_instr(addi_word(5'd4, 5'd0, 12'h7ff));
        issue_instr(alu_word(alu_add, 5'd5, 5'd1, 5'd2));
        issue_instr(alu_word(alu_and, 5'd7, 5'd1, 5'd3));
        issue_instr(alu_word(alu_xor, 5'd9, 5'd1, 5'd2));
        issue_instr(alu_word(alu_sub, 5'd6, 5'd3, 5'd4));
        issue_instr(alu_word(alu_or, 5'd8, 5'd2, 5'd4));
        issue_instr(alu_word(alu_slt, 5'd10, 5'd2, 5'd1));
        issue_instr(alu_word(alu_slt, 5'd11, 5'd1, 5'd2));
        drain_pipeline();
        finish_test("independent alu", errors_before, stalls_before);
    endtask

    task automatic forwarding_paths();
        int errors_before;
        int stalls_before;
        errors_before = fail_count;
        stalls_before = stall_count;
        issue_instr(addi_word(5'd1, 5'd0, 12'd10));
        issue_instr(alu_word(alu_add, 5'd2, 5'd1, 5'd1));
        issue_instr(alu_word(alu_add, 5'd3, 5'd2, 5'd1));
        issue_instr(addi_word(5'd6, 5'd0, 12'd7));
        issue_instr(addi_word(5'd7, 5'd0, 12'd2));
        issue_instr(alu_word(alu_add, 5'd8, 5'd6, 5'd6));
        // x9 in EX/MEM and MEM/WB at once, younger value wins
        issue_instr(addi_word(5'd9, 5'd0, 12'd1));
        issue_instr(addi_word(5'd9, 5'd0, 12'd2));
        issue_instr(alu_word(alu_add, 5'd10, 5'd9, 5'd9));
        issue_instr(alu_word(alu_or, 5'd11, 5'd0, 5'd9));
        drain_pipeline();
        finish_test("forwarding paths", errors_before, stalls_before);
    endtask

    task automatic x0_writes();
        int errors_before;
        int stalls_before;
        errors_before = fail_count;
        stalls_before = stall_count;
        issue_instr(addi_word(5'd0, 5'd0, 12'd5));
        issue_instr(alu_word(alu_add, 5'd3, 5'd0, 5'd0));
        issue_instr(addi_word(5'd0, 5'd0, 12'd7));
        issue_instr(addi_word(5'd4, 5'd0, 12'd1));
        issue_instr(alu_word(alu_add, 5'd0, 5'd4, 5'd4));
        issue_instr(alu_word(alu_add, 5'd5, 5'd0, 5'd4));
        // load into x0 must not stall its reader
        issue_instr(load_word(5'd0, 12'd8));
        issue_instr(alu_word(alu_add, 5'd6, 5'd0, 5'd0));
        drain_pipeline();
        finish_test("x0 writes", errors_before, stalls_before);
    endtask

    task automatic load_use_stall();
        int errors_before;
        int stalls_before;
        errors_before = fail_count;
        stalls_before = stall_count;
        issue_instr(addi_word(5'd1, 5'd0, 12'h055));
        issue_instr(store_word(5'd1, 12'd8));
        issue_instr(load_word(5'd2, 12'd8));
        issue_instr(alu_word(alu_add, 5'd3, 5'd2, 5'd2));
        issue_instr(load_word(5'd4, 12'd8));
        issue_instr(addi_word(5'd5, 5'd0, 12'd3));
        issue_instr(alu_word(alu_add, 5'd6, 5'd4, 5'd5));
        issue_instr(load_word(5'd7, 12'd8));
        // only rs2 depends on the load
        issue_instr(alu_word(alu_sub, 5'd8, 5'd0, 5'd7));
        drain_pipeline();
        a_two_stalls: assert (stall_count - stalls_before == 2)
            else report_error($sformatf("%0d stall cycles, expected 2",
                                        stall_count - stalls_before));
        finish_test("load-use stall", errors_before, stalls_before);
    endtask

    task automatic load_store_forward();
        int errors_before;
        int stalls_before;
        errors_before = fail_count;
        stalls_before = stall_count;
        issue_instr(addi_word(5'd1, 5'd0, 12'h123));
        issue_instr(store_word(5'd1, 12'd16));
        issue_instr(load_word(5'd2, 12'd16));
        // store data comes from the load in WB
        issue_instr(store_word(5'd2, 12'd20));
        issue_instr(load_word(5'd3, 12'd20));
        drain_pipeline();
        a_no_stall: assert (stall_count == stalls_before)
            else report_error("store of a loaded register stalled");
        finish_test("load-store forward", errors_before, stalls_before);
    endtask

    task automatic random_program();
        int          errors_before;
        int          stalls_before;
        logic [31:0] r1;
        logic [31:0] r2;
        errors_before = fail_count;
        stalls_before = stall_count;
        for (int i = 0; i < RANDOM_INSTRS; i++) begin
            r1 = next_random();
            r2 = next_random();
            issue_instr(random_instr(r1, r2));
        end
        drain_pipeline();
        finish_test("random program", errors_before, stalls_before);
    endtask

    initial begin
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        exp_tail      = '0;
        lcg_state     = 32'd71021;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        independent_alu();
        forwarding_paths();
        x0_writes();
        load_use_stall();
        load_store_forward();
        random_program();
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_forwarder.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core_top.sv
verif/tb_rv_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
